// File: Makefile
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f cached_afu.f \
		--top-module tb_cached_afu -Mdir $(OBJ_DIR) -o vtb_cached_afu

run: compile
	./$(OBJ_DIR)/vtb_cached_afu | tee run.log
	grep -q "All tests passed" run.log

clean:
	rm -rf $(OBJ_DIR) run.log

// File: cached_afu.f
hdl/afu_pkg.sv
hdl/command_if.sv
hdl/reset_control.sv
hdl/job_control.sv
hdl/wed_fetch.sv
hdl/command_engine.sv
hdl/error_control.sv
hdl/mmio_regs.sv
hdl/cached_afu.sv
sim/afu_host_model.sv
sim/tb_cached_afu.sv

// File: hdl/afu_pkg.sv
`default_nettype none

package afu_pkg;

  // Field widths
  localparam int ADDR_W   = 64;
  localparam int DATA_W   = 64;
  localparam int TAG_W    = 8;
  localparam int ERR_BITS = 8;

  // Job commands from the host
  typedef enum logic [1:0] {
    JOB_START   = 2'd0,
    JOB_RESET   = 2'd1,
    JOB_ILLEGAL = 2'd2
  } job_opcode_t;

  // Host command opcode, a single line read
  typedef enum logic [12:0] {
    CMD_READ_LINE = 13'h0A00
  } cmd_opcode_t;

  // Anything other than RESP_DONE counts as a failure
  typedef enum logic [1:0] {
    RESP_DONE   = 2'd0,
    RESP_AERROR = 2'd1,
    RESP_DERROR = 2'd2,
    RESP_FAILED = 2'd3
  } resp_code_t;

  ////////////////////////////////////////
  // MMIO register map, word addresses
  ////////////////////////////////////////
  typedef logic [3:0] mmio_addr_t;

  localparam mmio_addr_t MMIO_WED_SRC    = 4'd0;
  localparam mmio_addr_t MMIO_WED_DST    = 4'd1;
  localparam mmio_addr_t MMIO_WED_SIZE   = 4'd2;
  localparam mmio_addr_t MMIO_WED_STATUS = 4'd3;
  localparam mmio_addr_t MMIO_ERRORS     = 4'd4;
  localparam mmio_addr_t MMIO_SOFT_RESET = 4'd5;

  // Bit positions in the error vector
  localparam int ERR_JOB_OPCODE = 0;
  localparam int ERR_JOB_BUSY   = 1;
  localparam int ERR_MMIO_ADDR  = 2;
  localparam int ERR_MMIO_RO    = 3;
  localparam int ERR_RESP_CODE  = 4;
  localparam int ERR_RESP_TAG   = 5;

  // Work element descriptor, one field per buffer write offset
  typedef struct packed {
    logic [DATA_W-1:0] src;
    logic [DATA_W-1:0] dst;
    logic [DATA_W-1:0] size;
    logic [DATA_W-1:0] status;
  } wed_t;

endpackage

`default_nettype wire

// File: hdl/cached_afu.sv
`default_nettype none

module cached_afu
  import afu_pkg::*;
#(
  parameter int NUM_EXTERNAL_RESETS = 2
) (
  input  wire logic                clock,
  input  wire logic                rst_n,
  // Job control
  input  wire logic                job_valid,
  input  wire job_opcode_t         job_opcode,
  input  wire logic [ADDR_W-1:0]   job_address,
  output logic                     job_running,
  output logic                     job_done,
  output logic                     job_error,
  // Command and response
  output logic                     command_valid,
  output cmd_opcode_t              command_opcode,
  output logic [TAG_W-1:0]         command_tag,
  output logic [ADDR_W-1:0]        command_address,
  input  wire logic                response_valid,
  input  wire logic [TAG_W-1:0]    response_tag,
  input  wire resp_code_t          response_code,
  // Buffer writes
  input  wire logic                buffer_write_valid,
  input  wire logic [TAG_W-1:0]    buffer_write_tag,
  input  wire logic [1:0]          buffer_write_offset,
  input  wire logic [DATA_W-1:0]   buffer_write_data,
  // MMIO
  input  wire logic                mmio_valid,
  input  wire logic                mmio_write,
  input  wire mmio_addr_t          mmio_address,
  input  wire logic [DATA_W-1:0]   mmio_wdata,
  output logic                     mmio_ack,
  output logic [DATA_W-1:0]        mmio_rdata
);

  logic                           afu_rst_n;
  logic                           reset_job;
  logic                           reset_mmio;
  logic [NUM_EXTERNAL_RESETS-1:0] reset_requests;
  logic [ADDR_W-1:0]              wed_address;
  logic                           wed_done;
  wed_t                           wed;
  logic                           buffer_write_accept;
  logic [ERR_BITS-1:0]            error_pulses;
  logic [ERR_BITS-1:0]            errors;
  logic                           error_any;
  logic                           clear_errors;
  logic                           err_job_opcode;
  logic                           err_job_busy;
  logic                           err_mmio_addr;
  logic                           err_mmio_ro;
  logic                           err_resp_code;
  logic                           err_resp_tag;

  command_if cmd_if ();

  assign reset_requests = NUM_EXTERNAL_RESETS'({reset_mmio, reset_job});

  assign error_pulses[ERR_JOB_OPCODE]           = err_job_opcode;
  assign error_pulses[ERR_JOB_BUSY]             = err_job_busy;
  assign error_pulses[ERR_MMIO_ADDR]            = err_mmio_addr;
  assign error_pulses[ERR_MMIO_RO]              = err_mmio_ro;
  assign error_pulses[ERR_RESP_CODE]            = err_resp_code;
  assign error_pulses[ERR_RESP_TAG]             = err_resp_tag;
  assign error_pulses[ERR_BITS-1:ERR_RESP_TAG+1] = '0;

  ////////////////////////////////////////
  // Reset and job
  ////////////////////////////////////////
  reset_control #(
    .NUM_EXTERNAL_RESETS(NUM_EXTERNAL_RESETS)
  ) reset_instant (
    .clock          (clock),
    .rst_n          (rst_n),
    .reset_requests (reset_requests),
    .afu_rst_n      (afu_rst_n)
  );

  job_control job_instant (
    .clock          (clock),
    .afu_rst_n      (afu_rst_n),
    .job_valid      (job_valid),
    .job_opcode     (job_opcode),
    .job_address    (job_address),
    .wed_done       (wed_done),
    .error_any      (error_any),
    .job_running    (job_running),
    .job_done       (job_done),
    .job_error      (job_error),
    .reset_job      (reset_job),
    .wed_address    (wed_address),
    .err_job_opcode (err_job_opcode),
    .err_job_busy   (err_job_busy)
  );

  ////////////////////////////////////////
  // WED fetch and command path
  ////////////////////////////////////////
  wed_fetch wed_instant (
    .clock               (clock),
    .afu_rst_n           (afu_rst_n),
    .job_running         (job_running),
    .wed_address         (wed_address),
    .buffer_write_valid  (buffer_write_valid & buffer_write_accept),
    .buffer_write_offset (buffer_write_offset),
    .buffer_write_data   (buffer_write_data),
    .cmd                 (cmd_if.requester),
    .wed                 (wed),
    .wed_done            (wed_done)
  );

  command_engine command_instant (
    .clock               (clock),
    .afu_rst_n           (afu_rst_n),
    .cmd                 (cmd_if.engine),
    .command_valid       (command_valid),
    .command_opcode      (command_opcode),
    .command_tag         (command_tag),
    .command_address     (command_address),
    .response_valid      (response_valid),
    .response_tag        (response_tag),
    .response_code       (response_code),
    .buffer_write_tag    (buffer_write_tag),
    .buffer_write_accept (buffer_write_accept),
    .err_resp_code       (err_resp_code),
    .err_resp_tag        (err_resp_tag)
  );

  ////////////////////////////////////////
  // Errors and MMIO
  ////////////////////////////////////////
  error_control error_instant (
    .clock        (clock),
    .afu_rst_n    (afu_rst_n),
    .error_pulses (error_pulses),
    .clear        (clear_errors),
    .errors       (errors),
    .error_any    (error_any)
  );

  mmio_regs mmio_instant (
    .clock         (clock),
    .afu_rst_n     (afu_rst_n),
    .mmio_valid    (mmio_valid),
    .mmio_write    (mmio_write),
    .mmio_address  (mmio_address),
    .mmio_wdata    (mmio_wdata),
    .wed           (wed),
    .errors        (errors),
    .mmio_ack      (mmio_ack),
    .mmio_rdata    (mmio_rdata),
    .clear_errors  (clear_errors),
    .reset_mmio    (reset_mmio),
    .err_mmio_addr (err_mmio_addr),
    .err_mmio_ro   (err_mmio_ro)
  );

endmodule

`default_nettype wire

// File: hdl/command_engine.sv
`default_nettype none

module command_engine
  import afu_pkg::*;
(
  input  wire logic             clock,
  input  wire logic             afu_rst_n,
  command_if.engine             cmd,
  output logic                  command_valid,
  output cmd_opcode_t           command_opcode,
  output logic [TAG_W-1:0]      command_tag,
  output logic [ADDR_W-1:0]     command_address,
  input  wire logic             response_valid,
  input  wire logic [TAG_W-1:0] response_tag,
  input  wire resp_code_t       response_code,
  input  wire logic [TAG_W-1:0] buffer_write_tag,
  output logic                  buffer_write_accept,
  output logic                  err_resp_code,
  output logic                  err_resp_tag
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_ACK
  } state_t;

  state_t state;
  logic   issue;
  logic   tag_match;
  logic   complete;
  logic   foreign_seen;

  assign issue     = (state == ST_IDLE) && cmd.req;
  assign tag_match = (state == ST_WAIT) && (response_tag == command_tag);
  assign complete  = response_valid && tag_match;

  // Anything not answering the outstanding tag is foreign
  assign err_resp_tag        = response_valid && !tag_match;
  assign err_resp_code       = complete && (response_code != RESP_DONE);
  assign buffer_write_accept = (state == ST_WAIT) && (buffer_write_tag == command_tag);
  assign cmd.ack             = (state == ST_ACK);

  always_ff @(posedge clock or negedge afu_rst_n) begin
    if (!afu_rst_n) begin
      state         <= ST_IDLE;
      command_valid <= 1'b0;
      command_tag   <= '0;
      foreign_seen  <= 1'b0;
    end else begin
      command_valid <= issue;
      case (state)
        ST_IDLE: begin
          if (issue) begin
            command_tag  <= command_tag + TAG_W'(1);
            foreign_seen <= 1'b0;
            state        <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (err_resp_tag) foreign_seen <= 1'b1;
          if (complete) state <= ST_ACK;
        end
        default: begin
          // Ack held until the requester lets go
          if (!cmd.req) state <= ST_IDLE;
        end
      endcase
    end
  end

  // Command payload and completion status
  always_ff @(posedge clock) begin
    if (issue) begin
      command_address <= cmd.address;
      command_opcode  <= cmd.opcode;
    end
    if (complete) begin
      cmd.status_err_bits                <= '0;
      cmd.status_err_bits[ERR_RESP_CODE] <= (response_code != RESP_DONE);
      cmd.status_err_bits[ERR_RESP_TAG]  <= foreign_seen;
      cmd.status_ok <= (response_code == RESP_DONE) && !foreign_seen;
    end
  end

  // Single outstanding command
  assert property (@(posedge clock) disable iff (!afu_rst_n)
    command_valid |=> (!command_valid until cmd.ack));

endmodule

`default_nettype wire

// File: hdl/command_if.sv
`default_nettype none

interface command_if
  import afu_pkg::*;
();

  // Request side, address held while req is high
  logic                req;
  logic [ADDR_W-1:0]   address;
  cmd_opcode_t         opcode;

  // Completion side, status valid while ack is high
  logic                ack;
  logic                status_ok;
  logic [ERR_BITS-1:0] status_err_bits;

  modport requester (
    output req, address, opcode,
    input  ack, status_ok, status_err_bits
  );

  modport engine (
    input  req, address, opcode,
    output ack, status_ok, status_err_bits
  );

endinterface

`default_nettype wire

// File: hdl/error_control.sv
`default_nettype none

module error_control
  import afu_pkg::*;
(
  input  wire logic                clock,
  input  wire logic                afu_rst_n,
  input  wire logic [ERR_BITS-1:0] error_pulses,
  input  wire logic                clear,
  output logic [ERR_BITS-1:0]      errors,
  output logic                     error_any
);

  logic [ERR_BITS-1:0] kept;

  // A pulse in the clear cycle still lands
  assign kept = clear ? '0 : errors;

  always_ff @(posedge clock or negedge afu_rst_n) begin
    if (!afu_rst_n) begin
      errors <= '0;
    end else begin
      errors <= kept | error_pulses;
    end
  end

  assign error_any = |errors;

endmodule

`default_nettype wire

// File: hdl/job_control.sv
`default_nettype none

module job_control
  import afu_pkg::*;
(
  input  wire logic              clock,
  input  wire logic              afu_rst_n,
  input  wire logic              job_valid,
  input  wire job_opcode_t       job_opcode,
  input  wire logic [ADDR_W-1:0] job_address,
  input  wire logic              wed_done,
  input  wire logic              error_any,
  output logic                   job_running,
  output logic                   job_done,
  output logic                   job_error,
  output logic                   reset_job,
  output logic [ADDR_W-1:0]      wed_address,
  output logic                   err_job_opcode,
  output logic                   err_job_busy
);

  logic start_cmd;
  logic start_ok;
  logic job_end;

  assign start_cmd = job_valid && (job_opcode == JOB_START);
  // The done cycle still counts as busy
  assign start_ok  = start_cmd && !job_running && !job_done;
  assign job_end   = job_running && (wed_done || error_any);

  assign err_job_opcode = job_valid && (job_opcode != JOB_START) && (job_opcode != JOB_RESET);
  assign err_job_busy   = start_cmd && !start_ok;
  assign job_error      = job_done && error_any;

  // Idle/running state
  always_ff @(posedge clock or negedge afu_rst_n) begin
    if (!afu_rst_n) begin
      job_running <= 1'b0;
      job_done    <= 1'b0;
      reset_job   <= 1'b0;
    end else begin
      job_done  <= job_end;
      reset_job <= job_valid && (job_opcode == JOB_RESET);
      if (start_ok) begin
        job_running <= 1'b1;
      end else if (job_end) begin
        job_running <= 1'b0;
      end
    end
  end

  // WED pointer held for the whole job
  always_ff @(posedge clock) begin
    if (start_ok) begin
      wed_address <= job_address;
    end
  end

  // No start may be taken while the done pulse is out
  assert property (@(posedge clock) disable iff (!afu_rst_n)
    job_done |=> !job_running);

endmodule

`default_nettype wire

// File: hdl/mmio_regs.sv
`default_nettype none

module mmio_regs
  import afu_pkg::*;
(
  input  wire logic                clock,
  input  wire logic                afu_rst_n,
  input  wire logic                mmio_valid,
  input  wire logic                mmio_write,
  input  wire mmio_addr_t          mmio_address,
  input  wire logic [DATA_W-1:0]   mmio_wdata,
  input  wire wed_t                wed,
  input  wire logic [ERR_BITS-1:0] errors,
  output logic                     mmio_ack,
  output logic [DATA_W-1:0]        mmio_rdata,
  output logic                     clear_errors,
  output logic                     reset_mmio,
  output logic                     err_mmio_addr,
  output logic                     err_mmio_ro
);

  logic              s1_valid;
  logic              s1_write;
  mmio_addr_t        s1_addr;
  logic              s1_reset_req;
  logic              s1_mapped;
  logic [DATA_W-1:0] s1_rdata;

  ////////////////////////////////////////
  // Stage 1, request capture
  ////////////////////////////////////////
  always_ff @(posedge clock or negedge afu_rst_n) begin
    if (!afu_rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= mmio_valid;
    end
  end

  always_ff @(posedge clock) begin
    s1_write     <= mmio_write;
    s1_addr      <= mmio_address;
    // Any non-zero write data requests the reset
    s1_reset_req <= |mmio_wdata;
  end

  // Register map decode
  always_comb begin
    s1_mapped = 1'b1;
    case (s1_addr)
      MMIO_WED_SRC:    s1_rdata = wed.src;
      MMIO_WED_DST:    s1_rdata = wed.dst;
      MMIO_WED_SIZE:   s1_rdata = wed.size;
      MMIO_WED_STATUS: s1_rdata = wed.status;
      MMIO_ERRORS:     s1_rdata = DATA_W'(errors);
      MMIO_SOFT_RESET: s1_rdata = '0;
      default: begin
        s1_rdata  = '1;
        s1_mapped = 1'b0;
      end
    endcase
  end

  assign err_mmio_addr = s1_valid && !s1_mapped;
  assign err_mmio_ro   = s1_valid && s1_write && s1_mapped && (s1_addr != MMIO_SOFT_RESET);
  // Clear lands on the edge that captures the read data
  assign clear_errors  = s1_valid && !s1_write && (s1_addr == MMIO_ERRORS);

  ////////////////////////////////////////
  // Stage 2, acknowledge
  ////////////////////////////////////////
  always_ff @(posedge clock or negedge afu_rst_n) begin
    if (!afu_rst_n) begin
      mmio_ack   <= 1'b0;
      reset_mmio <= 1'b0;
    end else begin
      mmio_ack   <= s1_valid;
      reset_mmio <= s1_valid && s1_write && (s1_addr == MMIO_SOFT_RESET) && s1_reset_req;
    end
  end

  always_ff @(posedge clock) begin
    mmio_rdata <= s1_write ? '0 : s1_rdata;
  end

  // Fixed two-cycle latency
  assert property (@(posedge clock) disable iff (!afu_rst_n)
    mmio_ack |-> $past(mmio_valid, 2));

endmodule

`default_nettype wire

// File: hdl/reset_control.sv
`default_nettype none

module reset_control #(
  parameter int NUM_EXTERNAL_RESETS = 2
) (
  input  wire logic                           clock,
  input  wire logic                           rst_n,
  input  wire logic [NUM_EXTERNAL_RESETS-1:0] reset_requests,
  output logic                                afu_rst_n
);

  logic [1:0] req_q;
  logic       arst_n;
  logic [1:0] sync_q;

  // Stretch a one-cycle request to two cycles
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= '0;
    end else begin
      req_q <= {req_q[0], |reset_requests};
    end
  end

  assign arst_n = rst_n & ~(|req_q);

  // Assert at once, release through two clocked stages
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign afu_rst_n = sync_q[1];

endmodule

`default_nettype wire

// File: hdl/wed_fetch.sv
`default_nettype none

module wed_fetch
  import afu_pkg::*;
(
  input  wire logic              clock,
  input  wire logic              afu_rst_n,
  input  wire logic              job_running,
  input  wire logic [ADDR_W-1:0] wed_address,
  input  wire logic              buffer_write_valid,
  input  wire logic [1:0]        buffer_write_offset,
  input  wire logic [DATA_W-1:0] buffer_write_data,
  command_if.requester           cmd,
  output wed_t                   wed,
  output logic                   wed_done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_RELEASE,
    ST_HOLD
  } state_t;

  state_t state;

  assign cmd.req     = (state == ST_REQ);
  assign cmd.address = wed_address;
  assign cmd.opcode  = CMD_READ_LINE;
  // Handshake over once ack has dropped
  assign wed_done    = (state == ST_RELEASE) && !cmd.ack;

  // One fetch per job, HOLD waits for the job to end
  always_ff @(posedge clock or negedge afu_rst_n) begin
    if (!afu_rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:    if (job_running) state <= ST_REQ;
        ST_REQ:     if (cmd.ack) state <= ST_RELEASE;
        ST_RELEASE: if (!cmd.ack) state <= ST_HOLD;
        default:    if (!job_running) state <= ST_IDLE;
      endcase
    end
  end

  // Field capture, a failed read leaves no stale descriptor
  always_ff @(posedge clock or negedge afu_rst_n) begin
    if (!afu_rst_n) begin
      wed <= '0;
    end else if (state == ST_REQ) begin
      if (cmd.ack && !cmd.status_ok) begin
        wed <= '0;
      end else if (buffer_write_valid) begin
        case (buffer_write_offset)
          2'd0:    wed.src    <= buffer_write_data;
          2'd1:    wed.dst    <= buffer_write_data;
          2'd2:    wed.size   <= buffer_write_data;
          default: wed.status <= buffer_write_data;
        endcase
      end
    end
  end

  // Engine status agrees with its error bits
  assert property (@(posedge clock) disable iff (!afu_rst_n)
    cmd.ack |-> (cmd.status_ok == (cmd.status_err_bits == '0)));

endmodule

`default_nettype wire

// File: sim/afu_host_model.sv
`default_nettype none

module afu_host_model
  import afu_pkg::*;
#(
  parameter int SEED = 43
) (
  input  wire logic              clock,
  input  wire logic              command_valid,
  input  wire logic [TAG_W-1:0]  command_tag,
  input  wire logic [ADDR_W-1:0] command_address,
  // Set by the test before each job
  input  wire resp_code_t        answer_code,
  input  wire logic              send_foreign,
  output logic                   response_valid,
  output logic [TAG_W-1:0]       response_tag,
  output resp_code_t             response_code,
  output logic                   buffer_write_valid,
  output logic [TAG_W-1:0]       buffer_write_tag,
  output logic [1:0]             buffer_write_offset,
  output logic [DATA_W-1:0]      buffer_write_data,
  output wed_t                   wed_expected,
  output logic [ADDR_W-1:0]      address_seen,
  output int                     served
);

  timeunit 1ns;
  timeprecision 1ps;

  integer            seed;
  int                delay;
  int                first;
  logic [TAG_W-1:0]  tag;
  logic [1:0]        offset;
  logic [DATA_W-1:0] data;

  initial begin
    seed                = SEED;
    response_valid      = 1'b0;
    response_tag        = '0;
    response_code       = RESP_DONE;
    buffer_write_valid  = 1'b0;
    buffer_write_tag    = '0;
    buffer_write_offset = '0;
    buffer_write_data   = '0;
    wed_expected        = '0;
    address_seen        = '0;
    served              = 0;
    forever begin
      @(negedge clock);
      if (command_valid) begin
        tag          = command_tag;
        address_seen = command_address;
        delay        = 1 + ($unsigned($random(seed)) % 20);
        first        = $unsigned($random(seed)) % 4;
        repeat (delay) @(negedge clock);
        // Four line beats, starting at a random offset
        for (int i = 0; i < 4; i++) begin
          offset              = 2'(first + i);
          data                = {$random(seed), $random(seed)};
          buffer_write_valid  = 1'b1;
          buffer_write_tag    = tag;
          buffer_write_offset = offset;
          buffer_write_data   = data;
          case (offset)
            2'd0:    wed_expected.src    = data;
            2'd1:    wed_expected.dst    = data;
            2'd2:    wed_expected.size   = data;
            default: wed_expected.status = data;
          endcase
          @(negedge clock);
        end
        buffer_write_valid = 1'b0;
        if (send_foreign) begin
          response_valid = 1'b1;
          response_tag   = tag ^ 8'h80;
          response_code  = RESP_DONE;
          @(negedge clock);
          response_valid = 1'b0;
          @(negedge clock);
        end
        response_valid = 1'b1;
        response_tag   = tag;
        response_code  = answer_code;
        @(negedge clock);
        response_valid = 1'b0;
        // Failed reads leave the descriptor cleared
        if (send_foreign || (answer_code != RESP_DONE)) begin
          wed_expected = '0;
        end
        served <= served + 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_cached_afu.sv
`default_nettype none

module tb_cached_afu
  import afu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 500;

  logic              clock;
  logic              rst_n;
  logic              job_valid;
  job_opcode_t       job_opcode;
  logic [ADDR_W-1:0] job_address;
  logic              job_running;
  logic              job_done;
  logic              job_error;
  logic              command_valid;
  cmd_opcode_t       command_opcode;
  logic [TAG_W-1:0]  command_tag;
  logic [ADDR_W-1:0] command_address;
  logic              response_valid;
  logic [TAG_W-1:0]  response_tag;
  resp_code_t        response_code;
  logic              buffer_write_valid;
  logic [TAG_W-1:0]  buffer_write_tag;
  logic [1:0]        buffer_write_offset;
  logic [DATA_W-1:0] buffer_write_data;
  logic              mmio_valid;
  logic              mmio_write;
  mmio_addr_t        mmio_address;
  logic [DATA_W-1:0] mmio_wdata;
  logic              mmio_ack;
  logic [DATA_W-1:0] mmio_rdata;

  resp_code_t        answer_code;
  logic              send_foreign;
  wed_t              host_wed;
  logic [ADDR_W-1:0] host_address;
  int                host_served;

  integer seed;
  int     check_count;
  int     error_count;
  logic   timeout_hit;

  cached_afu #(
    .NUM_EXTERNAL_RESETS(2)
  ) u_dut (
    .clock, .rst_n,
    .job_valid, .job_opcode, .job_address, .job_running, .job_done, .job_error,
    .command_valid, .command_opcode, .command_tag, .command_address,
    .response_valid, .response_tag, .response_code,
    .buffer_write_valid, .buffer_write_tag, .buffer_write_offset, .buffer_write_data,
    .mmio_valid, .mmio_write, .mmio_address, .mmio_wdata, .mmio_ack, .mmio_rdata
  );

  afu_host_model #(
    .SEED(43)
  ) host (
    .clock, .command_valid, .command_tag, .command_address,
    .answer_code, .send_foreign,
    .response_valid, .response_tag, .response_code,
    .buffer_write_valid, .buffer_write_tag, .buffer_write_offset, .buffer_write_data,
    .wed_expected (host_wed),
    .address_seen (host_address),
    .served       (host_served)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;

  ////////////////////////////////////////
  // Checks and waits
  ////////////////////////////////////////
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    check_count++;
    assert (cond) else begin
      error_count++;
      $display("Error: %s", what);
    end
  endtask

  // Parks the caller, the watchdog ends the run
  task automatic stop_on_timeout(input string what);
    $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
    timeout_hit = 1'b1;
    forever @(negedge clock);
  endtask

  task automatic print_counts();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
  endtask

  task automatic settle(input int cycles);
    repeat (cycles) @(negedge clock);
  endtask

  function automatic logic [63:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic wait_job_done();
    int n;
    n = 0;
    while (!job_done) begin
      if (n == TIMEOUT) stop_on_timeout("job_done");
      @(negedge clock);
      n++;
    end
  endtask

  task automatic wait_served(input int target);
    int n;
    n = 0;
    while (host_served < target) begin
      if (n == TIMEOUT) stop_on_timeout("host response");
      @(negedge clock);
      n++;
    end
  endtask

  ////////////////////////////////////////
  // Host bus tasks
  ////////////////////////////////////////
  task automatic send_job(input job_opcode_t op, input logic [ADDR_W-1:0] addr);
    job_valid   = 1'b1;
    job_opcode  = op;
    job_address = addr;
    @(negedge clock);
    job_valid = 1'b0;
  endtask

  task automatic mmio_access(input logic write, input mmio_addr_t addr,
                             input logic [DATA_W-1:0] wdata,
                             output logic [DATA_W-1:0] rdata);
    int cycles;
    mmio_valid   = 1'b1;
    mmio_write   = write;
    mmio_address = addr;
    mmio_wdata   = wdata;
    @(negedge clock);
    mmio_valid = 1'b0;
    cycles     = 1;
    while (!mmio_ack) begin
      if (cycles == TIMEOUT) stop_on_timeout("mmio_ack");
      @(negedge clock);
      cycles++;
    end
    check_value("mmio_ack latency", cycles, 2);
    rdata = mmio_rdata;
  endtask

  task automatic check_wed(input wed_t exp);
    logic [DATA_W-1:0] data;
    mmio_access(1'b0, MMIO_WED_SRC, '0, data);
    check_value("mmio_rdata wed.src", data, exp.src);
    mmio_access(1'b0, MMIO_WED_DST, '0, data);
    check_value("mmio_rdata wed.dst", data, exp.dst);
    mmio_access(1'b0, MMIO_WED_SIZE, '0, data);
    check_value("mmio_rdata wed.size", data, exp.size);
    mmio_access(1'b0, MMIO_WED_STATUS, '0, data);
    check_value("mmio_rdata wed.status", data, exp.status);
  endtask

  // Read shows the bit, the read itself clears it
  task automatic check_errors(input int bit_pos);
    logic [DATA_W-1:0] data;
    mmio_access(1'b0, MMIO_ERRORS, '0, data);
    check_value("mmio_rdata errors", data, 64'd1 << bit_pos);
    mmio_access(1'b0, MMIO_ERRORS, '0, data);
    check_value("mmio_rdata errors after clear", data, '0);
  endtask

  task automatic check_cleared();
    logic [DATA_W-1:0] data;
    check_wed('0);
    mmio_access(1'b0, MMIO_ERRORS, '0, data);
    check_value("mmio_rdata errors after reset", data, '0);
    check_true(!job_running, "job_running high after reset");
  endtask

  task automatic run_job(input logic [ADDR_W-1:0] addr, input resp_code_t code,
                         input logic foreign, input logic expect_error);
    int target;
    target       = host_served + 1;
    answer_code  = code;
    send_foreign = foreign;
    send_job(JOB_START, addr);
    wait_job_done();
    check_value("job_error", job_error, expect_error);
    wait_served(target);
    check_value("command_address", host_address, addr);
    check_value("command_opcode", command_opcode, 64'h0A00);
    // Lets the fetch FSM return to idle
    settle(6);
    check_true(!job_running, "job_running still high after job_done");
  endtask

  initial begin : watchdog
    timeout_hit = 1'b0;
    @(posedge timeout_hit);
    print_counts();
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin : main_sequence
    logic [DATA_W-1:0] data;
    int                target;
    seed         = 43;
    check_count  = 0;
    error_count  = 0;
    rst_n        = 1'b0;
    job_valid    = 1'b0;
    job_opcode   = JOB_START;
    job_address  = '0;
    mmio_valid   = 1'b0;
    mmio_write   = 1'b0;
    mmio_address = '0;
    mmio_wdata   = '0;
    answer_code  = RESP_DONE;
    send_foreign = 1'b0;
    repeat (16) @(negedge clock);
    rst_n = 1'b1;
    settle(4);
    check_true(!job_running && !job_done && !command_valid && !mmio_ack,
               "outputs not idle after reset");

    // Single job, then eight in a row
    run_job(random_word(), RESP_DONE, 1'b0, 1'b0);
    check_wed(host_wed);
    repeat (8) begin
      run_job(random_word(), RESP_DONE, 1'b0, 1'b0);
      check_wed(host_wed);
    end

    // Failing response code, then a foreign tag first
    run_job(random_word(), resp_code_t'(1 + ($unsigned($random(seed)) % 3)), 1'b0, 1'b1);
    check_errors(ERR_RESP_CODE);
    check_wed(host_wed);
    run_job(random_word(), RESP_DONE, 1'b1, 1'b1);
    check_errors(ERR_RESP_TAG);
    check_wed(host_wed);

    // MMIO misuse
    mmio_access(1'b0, mmio_addr_t'(6 + ($unsigned($random(seed)) % 10)), '0, data);
    check_value("mmio_rdata unmapped", data, '1);
    check_errors(ERR_MMIO_ADDR);
    mmio_access(1'b1, MMIO_WED_SRC, random_word(), data);
    check_errors(ERR_MMIO_RO);
    mmio_access(1'b0, MMIO_WED_SRC, '0, data);
    check_value("mmio_rdata wed.src after write", data, host_wed.src);

    // Illegal opcode, then a start while running
    send_job(JOB_ILLEGAL, '0);
    settle(2);
    check_errors(ERR_JOB_OPCODE);
    answer_code  = RESP_DONE;
    send_foreign = 1'b0;
    target       = host_served + 1;
    send_job(JOB_START, random_word());
    send_job(JOB_START, random_word());
    wait_job_done();
    check_value("job_error", job_error, 1'b1);
    wait_served(target);
    settle(6);
    check_errors(ERR_JOB_BUSY);

    // Soft reset through MMIO
    run_job(random_word(), RESP_DONE, 1'b0, 1'b0);
    mmio_access(1'b0, 4'hF, '0, data);
    mmio_access(1'b1, MMIO_SOFT_RESET, random_word() | 64'd1, data);
    settle(8);
    check_cleared();

    // Job reset
    run_job(random_word(), RESP_DONE, 1'b0, 1'b0);
    send_job(JOB_ILLEGAL, '0);
    send_job(JOB_RESET, '0);
    settle(8);
    check_cleared();

    print_counts();
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
